/* rtl/fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl
  import fetch_pkg::*;
(
  input  wire   clk,
  input  wire   rst,

  // cache side
  input  wire   hit_i,
  input  word_t hit_inst_i,
  output addr_t fetch_pc_o,
  output logic  flush_o,

  // back end
  output word_t inst_o,
  output addr_t pc_o,
  output logic  inst_valid_o,
  input  wire   inst_ready_i,

  input  wire   redirect_i,
  input  addr_t redirect_pc_i,
  input  wire   resume_i
);

  fetch_state_t state_q;
  addr_t pc_q;

  logic [6:0] opcode;
  logic is_ctrl;
  logic is_load;
  logic is_fence_i;
  logic stall_inst;
  logic fire;
  addr_t pc_next_seq;

  assign opcode = hit_inst_i[6:0];

  // successor unknown until the back end resolves it
  assign is_ctrl = (opcode == OP_JAL) ||
                   (opcode == OP_JALR) ||
                   (opcode == OP_BRANCH) ||
                   (opcode == OP_SYSTEM);
  assign is_load = (opcode == OP_LOAD);
  assign is_fence_i = (hit_inst_i == INST_FENCE_I);
  assign stall_inst = is_ctrl || is_load || is_fence_i;

  assign pc_next_seq = addr_t'(pc_q + 32'd4);

  assign inst_valid_o = (state_q == RUN) && hit_i;
  assign inst_o = hit_inst_i;
  assign pc_o = pc_q;
  assign fetch_pc_o = pc_q;

  assign fire = inst_valid_o && inst_ready_i;

  // invalidate on the accepting cycle
  assign flush_o = fire && is_fence_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RUN;
      pc_q <= PC_INIT;
    end else begin
      case (state_q)
        RUN: begin
          if (fire) begin
            if (stall_inst) begin
              state_q <= STALL;
            end else begin
              pc_q <= pc_next_seq;
            end
          end
        end
        STALL: begin
          // redirect wins if both arrive together
          if (redirect_i) begin
            pc_q <= redirect_pc_i;
            state_q <= RUN;
          end else if (resume_i) begin
            pc_q <= pc_next_seq;
            state_q <= RUN;
          end
        end
        default: begin
          state_q <= RUN;
        end
      endcase
    end
  end

  // nothing leaves fetch until the stall is released
  a_stall_quiet: assert property (
    @(posedge clk) disable iff (rst)
    state_q == STALL && !redirect_i && !resume_i |=> !inst_valid_o
  ) else $error("inst_valid_o high while stalled");

  // back-pressure holds the offered instruction and its cache hit
  a_hold: assert property (
    @(posedge clk) disable iff (rst)
    inst_valid_o && !inst_ready_i |=>
      inst_valid_o && $stable(pc_o) && $stable(inst_o)
  ) else $error("pc_o/inst_o changed under back-pressure");

endmodule

`default_nettype wire

/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // cache geometry
  localparam int SETS = 4;
  localparam int LINE_WORDS = 2;
  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(SETS);

  // address split: tag | index | word offset | byte
  localparam int OFF_LSB = 2;
  localparam int IDX_LSB = OFF_LSB + OFF_W;
  localparam int TAG_LSB = IDX_LSB + IDX_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-TAG_LSB-1:0] tag_t;
  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [OFF_W-1:0] off_t;

  localparam addr_t PC_INIT = 32'h8000_0000;

  // rv32 major opcodes
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;

  // fence.i with all other fields zero
  localparam word_t INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT,
    DONE
  } cache_state_t;

  typedef enum logic {
    RUN,
    STALL
  } fetch_state_t;

endpackage

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  wire   clk,
  input  wire   rst,

  // axi4-lite read master
  output addr_t m_araddr_o,
  output logic  m_arvalid_o,
  input  wire   m_arready_i,
  input  word_t m_rdata_i,
  input  wire [1:0] m_rresp_i,
  input  wire   m_rvalid_i,
  output logic  m_rready_o,

  // back end
  output word_t inst_o,
  output addr_t pc_o,
  output logic  inst_valid_o,
  input  wire   inst_ready_i,
  input  wire   redirect_i,
  input  addr_t redirect_pc_i,
  input  wire   resume_i
);

  addr_t fetch_pc;
  logic flush;
  logic hit;
  word_t hit_inst;

  fetch_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .hit_i        (hit),
    .hit_inst_i   (hit_inst),
    .fetch_pc_o   (fetch_pc),
    .flush_o      (flush),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .inst_valid_o (inst_valid_o),
    .inst_ready_i (inst_ready_i),
    .redirect_i   (redirect_i),
    .redirect_pc_i(redirect_pc_i),
    .resume_i     (resume_i)
  );

  icache u_icache (
    .clk        (clk),
    .rst        (rst),
    .fetch_pc_i (fetch_pc),
    .flush_i    (flush),
    .hit_o      (hit),
    .hit_inst_o (hit_inst),
    .m_araddr_o (m_araddr_o),
    .m_arvalid_o(m_arvalid_o),
    .m_arready_i(m_arready_i),
    .m_rdata_i  (m_rdata_i),
    .m_rresp_i  (m_rresp_i),
    .m_rvalid_i (m_rvalid_i),
    .m_rready_o (m_rready_o)
  );

endmodule

`default_nettype wire

/* rtl/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache
  import fetch_pkg::*;
(
  input  wire   clk,
  input  wire   rst,

  input  addr_t fetch_pc_i,
  input  wire   flush_i,

  output logic  hit_o,
  output word_t hit_inst_o,

  output addr_t m_araddr_o,
  output logic  m_arvalid_o,
  input  wire   m_arready_i,
  input  word_t m_rdata_i,
  input  wire [1:0] m_rresp_i,
  input  wire   m_rvalid_i,
  output logic  m_rready_o
);

  // line storage
  word_t data_q [SETS][LINE_WORDS];
  tag_t tag_q [SETS];
  logic [SETS-1:0] valid_q;

  cache_state_t state_q;
  logic rready_q;

  // line being refilled
  tag_t miss_tag_q;
  idx_t miss_idx_q;
  off_t beat_q;

  tag_t pc_tag;
  idx_t pc_idx;
  off_t pc_off;

  logic line_hit;
  logic miss_start;
  logic ar_fire;
  logic r_fire;
  logic last_beat;

  assign pc_tag = fetch_pc_i[ADDR_W-1:TAG_LSB];
  assign pc_idx = fetch_pc_i[TAG_LSB-1:IDX_LSB];
  assign pc_off = fetch_pc_i[IDX_LSB-1:OFF_LSB];

  assign line_hit = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);

  // hit only reported once the FSM is back in IDLE
  assign hit_o = (state_q == IDLE) && line_hit;
  assign hit_inst_o = data_q[pc_idx][pc_off];

  assign miss_start = (state_q == IDLE) && !line_hit;
  assign ar_fire = m_arvalid_o && m_arready_i;
  assign r_fire = m_rvalid_i && m_rready_o;
  assign last_beat = (beat_q == off_t'(LINE_WORDS - 1));

  assign m_arvalid_o = (state_q == REQ);
  assign m_araddr_o = addr_t'({miss_tag_q, miss_idx_q, beat_q, {OFF_LSB{1'b0}}});
  assign m_rready_o = rready_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      valid_q <= '0;
      rready_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (miss_start) begin
            state_q <= REQ;
          end
        end
        REQ: begin
          if (ar_fire) begin
            state_q <= WAIT;
            rready_q <= 1'b1;
          end
        end
        WAIT: begin
          if (r_fire) begin
            rready_q <= 1'b0;
            if (last_beat) begin
              // whole line present now
              valid_q[miss_idx_q] <= 1'b1;
              state_q <= DONE;
            end else begin
              state_q <= REQ;
            end
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase

      // fence.i drops every line
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss_start) begin
      miss_tag_q <= pc_tag;
      miss_idx_q <= pc_idx;
      beat_q <= '0;
    end
    if (r_fire) begin
      data_q[miss_idx_q][beat_q] <= m_rdata_i;
      tag_q[miss_idx_q] <= miss_tag_q;
      beat_q <= off_t'(beat_q + 1'b1);
    end
  end

  // ar channel holds its request until accepted
  a_ar_stable: assert property (
    @(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o)
  ) else $error("araddr/arvalid changed before arready");

  a_rready_wait: assert property (
    @(posedge clk) disable iff (rst)
    m_rready_o |-> state_q == WAIT && !m_arvalid_o
  ) else $error("rready high outside WAIT");

endmodule

`default_nettype wire

/* tb.f */
rtl/fetch_pkg.sv
rtl/icache.sv
rtl/fetch_ctrl.sv
rtl/fetch_top.sv
tb/tb_axi_mem.sv
tb/tb_fetch.sv

/* tb/tb_axi_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem
  import fetch_pkg::*;
(
  input  wire   clk,
  input  wire   rst,

  // two 2-bit delays, ar in [1:0] and r in [3:2]
  input  wire [3:0] lat_i,

  input  addr_t araddr_i,
  input  wire   arvalid_i,
  output logic  arready_o,
  output word_t rdata_o,
  output logic [1:0] rresp_o,
  output logic  rvalid_o,
  input  wire   rready_i
);

  localparam int MEM_WORDS = 256;
  localparam int IDX_HI = $clog2(MEM_WORDS) + 1;

  // program image, loaded by the testbench before reset ends
  word_t mem_q [MEM_WORDS];

  logic busy_q;
  logic [1:0] ar_wait_q;
  logic [1:0] r_wait_q;
  addr_t addr_q;

  assign arready_o = !rst && arvalid_i && !busy_q && (ar_wait_q == 2'd0);
  assign rvalid_o = !rst && busy_q && (r_wait_q == 2'd0);
  assign rdata_o = rvalid_o ? mem_q[addr_q[IDX_HI:2]] : '0;
  assign rresp_o = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      ar_wait_q <= lat_i[1:0];
      r_wait_q <= 2'd0;
      addr_q <= '0;
    end else if (!busy_q) begin
      if (arready_o) begin
        busy_q <= 1'b1;
        addr_q <= araddr_i;
        r_wait_q <= lat_i[3:2];
      end else if (arvalid_i && ar_wait_q != 2'd0) begin
        ar_wait_q <= ar_wait_q - 2'd1;
      end
    end else begin
      if (rvalid_o && rready_i) begin
        busy_q <= 1'b0;
        ar_wait_q <= lat_i[1:0];
      end else if (r_wait_q != 2'd0) begin
        r_wait_q <= r_wait_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch
  import fetch_pkg::*;
();

  localparam int NUM_INST = 2000;
  localparam int CYCLES_PER_INST = 40;
  localparam int CLK_PERIOD = 8;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [6:0] OP_IMM = 7'b0010011;

  logic clk;
  logic rst;
  addr_t m_araddr;
  logic m_arvalid;
  logic m_arready;
  word_t m_rdata;
  logic [1:0] m_rresp;
  logic m_rvalid;
  logic m_rready;
  word_t inst_o;
  addr_t pc_o;
  logic inst_valid_o;
  logic inst_ready_i;
  logic redirect_i;
  addr_t redirect_pc_i;
  logic resume_i;
  logic [3:0] mem_lat;

  logic [31:0] lfsr_q;
  int mismatches;
  int other_errs;
  int accepted;
  int refills;
  addr_t exp_pc;
  addr_t last_pc;
  addr_t stall_pc;
  addr_t held_pc;
  addr_t ar_line;
  word_t stall_inst;
  word_t held_inst;
  logic stall_pending;
  logic held;
  logic ar_beat;
  logic gap_armed;
  logic [1:0] gap;
  // lines the cache should hold right now
  logic [SETS-1:0] shadow_valid;
  addr_t shadow_line [SETS];

  fetch_top dut (
    .clk(clk), .rst(rst),
    .m_araddr_o(m_araddr), .m_arvalid_o(m_arvalid), .m_arready_i(m_arready),
    .m_rdata_i(m_rdata), .m_rresp_i(m_rresp), .m_rvalid_i(m_rvalid), .m_rready_o(m_rready),
    .inst_o(inst_o), .pc_o(pc_o), .inst_valid_o(inst_valid_o), .inst_ready_i(inst_ready_i),
    .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i), .resume_i(resume_i)
  );

  tb_axi_mem u_mem (
    .clk(clk), .rst(rst), .lat_i(mem_lat),
    .araddr_i(m_araddr), .arvalid_i(m_arvalid), .arready_o(m_arready),
    .rdata_o(m_rdata), .rresp_o(m_rresp), .rvalid_o(m_rvalid), .rready_i(m_rready)
  );

  // galois lfsr stepped once per bit
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic word_t random_inst();
    logic [2:0] kind;
    kind = 3'(draw_bits(3));
    case (kind)
      3'd4: return {25'(draw_bits(25)), OP_BRANCH};
      3'd5: return {25'(draw_bits(25)), OP_LOAD};
      3'd6: return INST_FENCE_I;
      3'd7: return {25'(draw_bits(25)), OP_JAL};
      default: return {25'(draw_bits(25)), OP_IMM};
    endcase
  endfunction

  function automatic logic needs_redirect(input word_t inst);
    return inst[6:0] == OP_JAL || inst[6:0] == OP_JALR || inst[6:0] == OP_BRANCH;
  endfunction

  function automatic logic stalls_fetch(input word_t inst);
    return needs_redirect(inst) || inst[6:0] == OP_SYSTEM || inst[6:0] == OP_LOAD ||
           inst == INST_FENCE_I;
  endfunction

  function automatic addr_t expected_next(input addr_t pc, input word_t inst,
                                          input logic redir, input addr_t redir_pc);
    if (stalls_fetch(inst) && redir) begin
      return redir_pc;
    end
    return pc + 32'd4;
  endfunction

  function automatic word_t word_at(input addr_t a);
    return u_mem.mem_q[a[9:2]];
  endfunction

  function automatic addr_t line_of(input addr_t a);
    return {a[ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
  endfunction

  function automatic int set_of(input addr_t a);
    return int'(a[TAG_LSB-1:IDX_LSB]);
  endfunction

  function automatic logic line_resident(input addr_t a);
    return shadow_valid[set_of(a)] && shadow_line[set_of(a)] == line_of(a);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act === exp) else begin
      mismatches++;
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic expect_true(input logic ok, input string what);
    assert (ok === 1'b1) else begin
      other_errs++;
      $display("Error at %0t ns: %s", $time, what);
    end
  endtask

  task automatic check_ar(input addr_t a);
    expect_true(a[1:0] == 2'b00, "AR address is not word-aligned");
    if (!ar_beat) begin
      // stalled pc may still be refilling after a flush
      expect_true(line_of(a) == line_of(pc_o) || line_of(a) == line_of(last_pc),
                  "AR address outside the line being fetched");
      expect_true(a == line_of(a), "refill did not start at word 0 of the line");
      expect_true(!line_resident(a), "AR issued for a line that is already cached");
      ar_line = line_of(a);
      shadow_valid[set_of(a)] = 1'b0;
      ar_beat = 1'b1;
    end else begin
      compare_value("m_araddr_o", ar_line + 32'd4, a);
      shadow_line[set_of(a)] = ar_line;
      shadow_valid[set_of(a)] = 1'b1;
      ar_beat = 1'b0;
      refills++;
    end
  endtask

  task automatic finish_run(input logic timed_out);
    if (timed_out) begin
      other_errs++;
      $display("Error: watchdog expired after %0d accepted instructions", accepted);
    end
    $display("accepted %0d, refills %0d, mismatches %0d, other errors %0d",
             accepted, refills, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    int i;
    rst = 1'b1;
    inst_ready_i = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = PC_INIT;
    resume_i = 1'b0;
    mem_lat = 4'd0;
    lfsr_q = 32'd40;
    mismatches = 0;
    other_errs = 0;
    accepted = 0;
    refills = 0;
    exp_pc = PC_INIT;
    last_pc = PC_INIT;
    stall_pending = 1'b0;
    held = 1'b0;
    ar_beat = 1'b0;
    gap_armed = 1'b0;
    gap = 2'd0;
    shadow_valid = '0;
    for (i = 0; i < 256; i++) begin
      u_mem.mem_q[i] = random_inst();
    end
    repeat (3) @(posedge clk);
    @(negedge clk) rst <= 1'b0;
    expect_true(!inst_valid_o && !m_arvalid && !m_rready, "outputs not idle after reset");
    wait (accepted >= NUM_INST);
    @(negedge clk);
    finish_run(1'b0);
  end

  initial begin
    #(NUM_INST * CYCLES_PER_INST * CLK_PERIOD);
    finish_run(1'b1);
  end

  // back end drives ready and the release pulses
  always @(negedge clk) begin
    if (!rst) begin
      redirect_i = 1'b0;
      resume_i = 1'b0;
      inst_ready_i = (draw_bits(2) != 0);
      mem_lat = 4'(draw_bits(4));
      if (stall_pending) begin
        if (!gap_armed) begin
          gap = 2'(draw_bits(2));
          gap_armed = 1'b1;
        end
        if (gap != 2'd0) begin
          gap = gap - 2'd1;
        end else begin
          gap_armed = 1'b0;
          if (needs_redirect(stall_inst)) begin
            redirect_pc_i = PC_INIT + (draw_bits(8) << 2);
            redirect_i = 1'b1;
          end else begin
            resume_i = 1'b1;
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (stall_pending) begin
        expect_true(!inst_valid_o, "inst_valid_o high while a stall is pending");
        if (redirect_i || resume_i) begin
          exp_pc = expected_next(stall_pc, stall_inst, redirect_i, redirect_pc_i);
          stall_pending = 1'b0;
        end
      end
      if (held) begin
        expect_true(inst_valid_o, "inst_valid_o dropped before the instruction was accepted");
        compare_value("pc_o", held_pc, pc_o);
        compare_value("inst_o", held_inst, inst_o);
      end
      held = inst_valid_o && !inst_ready_i;
      held_pc = pc_o;
      held_inst = inst_o;
      if (m_arvalid && m_arready) begin
        check_ar(m_araddr);
      end
      if (inst_valid_o && inst_ready_i) begin
        compare_value("pc_o", exp_pc, pc_o);
        compare_value("inst_o", word_at(pc_o), inst_o);
        expect_true(line_resident(pc_o), "instruction delivered from a line never refilled");
        last_pc = pc_o;
        accepted++;
        if (stalls_fetch(inst_o)) begin
          stall_pending = 1'b1;
          stall_pc = pc_o;
          stall_inst = inst_o;
          if (inst_o == INST_FENCE_I) begin
            shadow_valid = '0;
          end
        end else begin
          exp_pc = expected_next(pc_o, inst_o, 1'b0, '0);
        end
      end
    end
  end

endmodule

`default_nettype wire
